//--- source/scramblerPkg.sv
// scrambler link package
// word and state widths, lane limits, lane seeds and the lane word type
package scramblerPkg;

    localparam int DataW    = 64;
    localparam int StateW   = 58;
    localparam int MaxLanes = 8;
    localparam int LaneIdxW = $clog2(MaxLanes);

    // lane index travels with its data word
    typedef struct packed {
        logic [LaneIdxW-1:0] lane;
        logic [DataW-1:0]    data;
    } laneWord_t;

    // all ones with low bits set to lane ^ 7, so every seed is nonzero and distinct
    function automatic logic [StateW-1:0] laneSeed(input int unsigned lane);
        logic [StateW-1:0] seed;
        seed = '1;
        seed[LaneIdxW-1:0] = LaneIdxW'(lane) ^ {LaneIdxW{1'b1}};
        return seed;
    endfunction

endpackage

//--- source/laneScrambler.sv
// lane scrambler, additive x^58 + x^39 + 1 generator
// XORs a 64-bit keystream onto each strobed word and advances 64 bit times
`timescale 1ns/1ps

module laneScrambler #(
    parameter logic [scramblerPkg::StateW-1:0] Seed = '1
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           reseed,
    input  logic                           en,
    input  logic [scramblerPkg::DataW-1:0] dataIn,
    output logic [scramblerPkg::DataW-1:0] dataOut,
    output logic                           outValid
);
    import scramblerPkg::*;

    // second tap of the polynomial, counted like the degree
    localparam int Tap  = 39;
    // keystream bits beyond the state window
    localparam int ExtW = DataW - StateW;

    logic [StateW-1:0] state;
    logic [ExtW-1:0]   extBits;
    logic [DataW-1:0]  keyStream;
    logic [StateW-1:0] nextState;

    // ========================================
    // keystream taps
    // ========================================
    // b[n] = b[n-58] ^ b[n-39], oldest bit at the msb of the state
    always_comb begin
        for (int i = 0; i < ExtW; i++) begin
            extBits[i] = state[i + StateW - ExtW] ^ state[i + Tap - ExtW];
        end
    end

    assign keyStream = {state, extBits};

    // window slides by a full word
    assign nextState = keyStream[StateW-1:0];

    // ========================================
    // state and output registers
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= Seed;
            dataOut  <= '0;
            outValid <= 1'b0;
        end else begin
            outValid <= en;
            if (en) begin
                dataOut <= dataIn ^ keyStream;
            end
            // a word taken with reseed still uses the old state
            if (reseed) begin
                state <= Seed;
            end else if (en) begin
                state <= nextState;
            end
        end
    end

endmodule

//--- source/txStriper.sv
// transmit striper
// registers incoming words and deals them round-robin across the lanes
`timescale 1ns/1ps

module txStriper #(
    parameter int NumLanes = 4
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           reseed,
    input  logic                           txValid,
    input  logic [scramblerPkg::DataW-1:0] txData,
    output logic                           stripeValid,
    output scramblerPkg::laneWord_t        stripeWord
);
    import scramblerPkg::*;

    logic [LaneIdxW-1:0] lanePtr;
    logic [LaneIdxW-1:0] curLane;
    logic [LaneIdxW-1:0] laneQ;
    logic [DataW-1:0]    dataQ;

    // reseed sends a word in the same cycle to lane 0 as well
    assign curLane = reseed ? '0 : lanePtr;

    always_ff @(posedge clk) begin
        if (rst) begin
            lanePtr     <= '0;
            stripeValid <= 1'b0;
        end else begin
            stripeValid <= txValid;
            if (txValid) begin
                lanePtr <= (curLane == LaneIdxW'(NumLanes - 1)) ? '0 : curLane + 1'b1;
            end else begin
                lanePtr <= curLane;
            end
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (txValid) begin
            laneQ <= curLane;
            dataQ <= txData;
        end
    end

    assign stripeWord = '{lane: laneQ, data: dataQ};

endmodule

//--- source/laneBank.sv
// lane bank, one scrambler per lane
// routes each word to its lane and merges the registered results into one stream
`timescale 1ns/1ps

module laneBank #(
    parameter int NumLanes = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    reseed,
    input  logic                    inValid,
    input  scramblerPkg::laneWord_t inWord,
    output logic                    outValid,
    output scramblerPkg::laneWord_t outWord
);
    import scramblerPkg::*;

    logic [NumLanes-1:0] laneEn;
    logic [NumLanes-1:0] laneValid;
    logic [DataW-1:0]    laneData [NumLanes];
    logic [LaneIdxW-1:0] laneIdxQ;
    logic [DataW-1:0]    outData;

    // ========================================
    // lane generators
    // ========================================
    for (genvar i = 0; i < NumLanes; i++) begin : gLane
        // out of range indices enable no lane
        assign laneEn[i] = inValid && (inWord.lane == LaneIdxW'(i));

        laneScrambler #(
            .Seed(laneSeed(i))
        ) u_laneScrambler (
            .clk     (clk),
            .rst     (rst),
            .reseed  (reseed),
            .en      (laneEn[i]),
            .dataIn  (inWord.data),
            .dataOut (laneData[i]),
            .outValid(laneValid[i])
        );
    end

    // lane index follows the data by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            laneIdxQ <= '0;
        end else if (inValid) begin
            laneIdxQ <= inWord.lane;
        end
    end

    // ========================================
    // collection
    // ========================================
    // at most one lane is valid per cycle
    always_comb begin
        outData = '0;
        for (int i = 0; i < NumLanes; i++) begin
            if (laneValid[i]) begin
                outData = laneData[i];
            end
        end
    end

    assign outValid = |laneValid;
    assign outWord  = '{lane: laneIdxQ, data: outData};

endmodule

//--- source/scramblerLink.sv
// multi-lane scrambling link top
// striper and scrambling bank on transmit, descrambling bank on receive
`timescale 1ns/1ps

module scramblerLink #(
    parameter int NumLanes = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              reseed,
    // transmit side
    input  logic                              txValid,
    input  logic [scramblerPkg::DataW-1:0]    txData,
    output logic                              lineValid,
    output logic [scramblerPkg::LaneIdxW-1:0] lineLane,
    output logic [scramblerPkg::DataW-1:0]    lineData,
    // receive side
    input  logic                              lineInValid,
    input  logic [scramblerPkg::LaneIdxW-1:0] lineInLane,
    input  logic [scramblerPkg::DataW-1:0]    lineInData,
    output logic                              rxValid,
    output logic [scramblerPkg::LaneIdxW-1:0] rxLane,
    output logic [scramblerPkg::DataW-1:0]    rxData
);
    import scramblerPkg::*;

    logic      stripeValid;
    laneWord_t stripeWord;
    laneWord_t lineWord;
    laneWord_t lineInWord;
    laneWord_t rxWord;

    // ========================================
    // transmit
    // ========================================
    txStriper #(
        .NumLanes(NumLanes)
    ) u_txStriper (
        .clk        (clk),
        .rst        (rst),
        .reseed     (reseed),
        .txValid    (txValid),
        .txData     (txData),
        .stripeValid(stripeValid),
        .stripeWord (stripeWord)
    );

    laneBank #(
        .NumLanes(NumLanes)
    ) u_txBank (
        .clk     (clk),
        .rst     (rst),
        .reseed  (reseed),
        .inValid (stripeValid),
        .inWord  (stripeWord),
        .outValid(lineValid),
        .outWord (lineWord)
    );

    assign lineLane = lineWord.lane;
    assign lineData = lineWord.data;

    // ========================================
    // receive
    // ========================================
    assign lineInWord = '{lane: lineInLane, data: lineInData};

    laneBank #(
        .NumLanes(NumLanes)
    ) u_rxBank (
        .clk     (clk),
        .rst     (rst),
        .reseed  (reseed),
        .inValid (lineInValid),
        .inWord  (lineInWord),
        .outValid(rxValid),
        .outWord (rxWord)
    );

    assign rxLane = rxWord.lane;
    assign rxData = rxWord.data;

endmodule

//--- verif/linkModel.svh
// link reference model
// serial x^58 + x^39 + 1 generator, lane seeds and keystream state per lane and direction
`ifndef LINK_MODEL_SVH
`define LINK_MODEL_SVH

localparam int ModelStateW = 58;
localparam int ModelWordW  = 64;
localparam int ModelLanes  = 8;

// one window per lane for each direction
logic [ModelStateW-1:0] txState [ModelLanes];
logic [ModelStateW-1:0] rxState [ModelLanes];

// all ones, low three bits are lane ^ 7
function automatic logic [ModelStateW-1:0] seedOf(input logic [2:0] lane);
    logic [ModelStateW-1:0] s;
    s = '1;
    s[2:0] = lane ^ 3'b111;
    return s;
endfunction

// 64 serial bits from a window, b[0] at the msb of the window
function automatic logic [ModelWordW-1:0] wordKey(input logic [ModelStateW-1:0] win);
    logic                  b [ModelWordW];
    logic [ModelWordW-1:0] key;
    for (int n = 0; n < ModelStateW; n++) begin
        b[n] = win[ModelStateW-1-n];
    end
    for (int n = ModelStateW; n < ModelWordW; n++) begin
        b[n] = b[n-58] ^ b[n-39];
    end
    for (int n = 0; n < ModelWordW; n++) begin
        key[ModelWordW-1-n] = b[n];
    end
    return key;
endfunction

// keystream for the next word, then the window keeps the last 58 bits
function automatic logic [ModelWordW-1:0] takeTxKey(input logic [2:0] lane);
    logic [ModelWordW-1:0] key;
    key = wordKey(txState[lane]);
    txState[lane] = key[ModelStateW-1:0];
    return key;
endfunction

function automatic logic [ModelWordW-1:0] takeRxKey(input logic [2:0] lane);
    logic [ModelWordW-1:0] key;
    key = wordKey(rxState[lane]);
    rxState[lane] = key[ModelStateW-1:0];
    return key;
endfunction

function automatic void resetModel();
    for (int i = 0; i < ModelLanes; i++) begin
        txState[i] = seedOf(3'(i));
        rxState[i] = seedOf(3'(i));
    end
endfunction

`endif

//--- verif/scramblerLinkTb.sv
// scrambler link testbench
// directed tests with a serial reference model and line loopback
`timescale 1ns/1ps

module scramblerLinkTb;

    localparam int NumLanes  = 4;
    localparam int WaitLimit = 200;

    logic        clk;
    logic        rst;
    logic        reseed;
    logic        txValid;
    logic [63:0] txData;
    logic        lineValid;
    logic [2:0]  lineLane;
    logic [63:0] lineData;
    logic        lineInValid = 1'b0;
    logic [2:0]  lineInLane  = 3'd0;
    logic [63:0] lineInData  = 64'd0;
    logic        rxValid;
    logic [2:0]  rxLane;
    logic [63:0] rxData;

    int unsigned errors;
    int unsigned testsRun;
    int unsigned checked;
    logic [2:0]  modelLane;

    // expected values per word in send order
    logic [2:0]  expLane [$];
    logic [63:0] expLine [$];
    logic [63:0] expRx [$];
    logic [63:0] flipMask [$];
    // seen on the DUT outputs
    logic [2:0]  gotLineLane [$];
    logic [63:0] gotLineData [$];
    logic [2:0]  gotRxLane [$];
    logic [63:0] gotRxData [$];

    `include "linkModel.svh"

    scramblerLink #(
        .NumLanes(NumLanes)
    ) u_scramblerLink (
        .clk        (clk),
        .rst        (rst),
        .reseed     (reseed),
        .txValid    (txValid),
        .txData     (txData),
        .lineValid  (lineValid),
        .lineLane   (lineLane),
        .lineData   (lineData),
        .lineInValid(lineInValid),
        .lineInLane (lineInLane),
        .lineInData (lineInData),
        .rxValid    (rxValid),
        .rxLane     (rxLane),
        .rxData     (rxData)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ========================================
    // monitor and line loopback
    // ========================================
    always @(negedge clk) begin
        logic [63:0] flip;
        flip = '0;
        if (lineValid) begin
            flip = flipMask[gotLineData.size()];
            gotLineLane.push_back(lineLane);
            gotLineData.push_back(lineData);
        end
        if (rxValid) begin
            gotRxLane.push_back(rxLane);
            gotRxData.push_back(rxData);
        end
        lineInValid = lineValid;
        lineInLane  = lineLane;
        lineInData  = lineData ^ flip;
    end

    // ========================================
    // helpers
    // ========================================
    task automatic sendWord(input logic [63:0] word, input logic [63:0] mask,
                            input int unsigned gap);
        logic [63:0] line;
        line = word ^ takeTxKey(modelLane);
        expLane.push_back(modelLane);
        expLine.push_back(line);
        expRx.push_back(line ^ mask ^ takeRxKey(modelLane));
        flipMask.push_back(mask);
        modelLane = (modelLane == 3'(NumLanes - 1)) ? 3'd0 : modelLane + 3'd1;
        @(negedge clk);
        txValid = 1'b1;
        txData  = word;
        repeat (gap) begin
            @(negedge clk);
            txValid = 1'b0;
        end
    endtask

    task automatic drainAndCompare();
        int unsigned waited;
        @(negedge clk);
        txValid = 1'b0;
        waited = 0;
        while (gotRxData.size() < expRx.size() && waited < WaitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (gotRxData.size() < expRx.size()) begin
            $display("timed out waiting for rxValid, %0d of %0d words received",
                     gotRxData.size(), expRx.size());
            errors++;
        end
        // one line word and one received word per strobe
        assert (gotLineData.size() == expRx.size() && gotRxData.size() == expRx.size()) else begin
            $display("ERROR: lineValid count %h rxValid count %h expected %h",
                     gotLineData.size(), gotRxData.size(), expRx.size());
            errors++;
        end
        for (int i = int'(checked); i < gotRxData.size() && i < expRx.size(); i++) begin
            assert (gotLineLane[i] === expLane[i]) else begin
                $display("ERROR: lineLane word %0d got %h expected %h",
                         i, gotLineLane[i], expLane[i]);
                errors++;
            end
            assert (gotLineData[i] === expLine[i]) else begin
                $display("ERROR: lineData word %0d got %h expected %h",
                         i, gotLineData[i], expLine[i]);
                errors++;
            end
            assert (gotRxLane[i] === expLane[i]) else begin
                $display("ERROR: rxLane word %0d got %h expected %h",
                         i, gotRxLane[i], expLane[i]);
                errors++;
            end
            assert (gotRxData[i] === expRx[i]) else begin
                $display("ERROR: rxData word %0d got %h expected %h",
                         i, gotRxData[i], expRx[i]);
                errors++;
            end
        end
        checked = expRx.size();
    endtask

    task automatic reportTest(input string name, input int unsigned startErr);
        testsRun++;
        $display("test %s done, %0d errors", name, errors - startErr);
    endtask

    // ========================================
    // tests
    // ========================================
    task automatic idleOutputs();
        int unsigned startErr;
        startErr = errors;
        repeat (20) begin
            @(negedge clk);
            assert (lineValid === 1'b0 && rxValid === 1'b0) else begin
                $display("ERROR: lineValid %h rxValid %h expected 0", lineValid, rxValid);
                errors++;
            end
            assert (lineData === '0 && lineLane === '0) else begin
                $display("ERROR: lineData %h lineLane %h expected 0", lineData, lineLane);
                errors++;
            end
            assert (rxData === '0 && rxLane === '0) else begin
                $display("ERROR: rxData %h rxLane %h expected 0", rxData, rxLane);
                errors++;
            end
        end
        reportTest("idle after reset", startErr);
    endtask

    task automatic burstWords();
        int unsigned startErr;
        startErr = errors;
        for (int i = 0; i < 12; i++) begin
            sendWord({$urandom, $urandom}, '0, 0);
        end
        drainAndCompare();
        reportTest("back-to-back words", startErr);
    endtask

    task automatic gappedWords();
        int unsigned startErr;
        startErr = errors;
        for (int i = 0; i < 12; i++) begin
            sendWord({$urandom, $urandom}, '0, $urandom % 6);
        end
        drainAndCompare();
        reportTest("words with gaps", startErr);
    endtask

    task automatic midStreamReseed();
        int unsigned startErr;
        startErr = errors;
        // leave the striper off lane 0
        for (int i = 0; i < 3; i++) begin
            sendWord({$urandom, $urandom}, '0, 0);
        end
        drainAndCompare();
        @(negedge clk);
        reseed = 1'b1;
        @(negedge clk);
        reseed = 1'b0;
        resetModel();
        modelLane = 3'd0;
        for (int i = 0; i < 8; i++) begin
            sendWord({$urandom, $urandom}, '0, 0);
        end
        drainAndCompare();
        reportTest("reseed mid-stream", startErr);
    endtask

    task automatic lineBitFlips();
        int unsigned startErr;
        logic [63:0] mask;
        startErr = errors;
        for (int i = 0; i < 8; i++) begin
            // two flipped bits on odd words and clean even words
            mask = (i % 2 == 1) ? ((64'h1 << (i * 8)) | (64'h1 << 63)) : '0;
            sendWord({$urandom, $urandom}, mask, 0);
        end
        drainAndCompare();
        reportTest("line bit flips", startErr);
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        void'($urandom(4));
        rst       = 1'b1;
        reseed    = 1'b0;
        txValid   = 1'b0;
        txData    = '0;
        errors    = 0;
        testsRun  = 0;
        checked   = 0;
        modelLane = 3'd0;
        resetModel();
        repeat (10) @(negedge clk);
        rst = 1'b0;

        idleOutputs();
        burstWords();
        gappedWords();
        midStreamReseed();
        lineBitFlips();

        $display("tests %0d, words %0d, errors %0d", testsRun, expRx.size(), errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // overall limit on the run
    initial begin
        #200us;
        $display("simulation did not finish within the time limit");
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+verif
source/scramblerPkg.sv
source/laneScrambler.sv
source/txStriper.sv
source/laneBank.sv
source/scramblerLink.sv
verif/scramblerLinkTb.sv

//--- run.sh
#!/bin/sh
# build and run the scrambler link testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module scramblerLinkTb \
    --Mdir obj_dir \
    -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
